//--- common/ni_pkg.sv
// ****************************
// Shared definitions for the NoC network interface
// Widths, flit type and host/link structs
// ****************************
`default_nettype none

package ni_pkg;

  // ****************************
  // Sizes
  // ****************************

  // Host data word
  localparam int FLIT_DATA = 32;
  // Two type bits sit above the data on the link
  localparam int FLIT_TYPE_WIDTH = 2;
  localparam int FLIT_WIDTH = FLIT_DATA + FLIT_TYPE_WIDTH;

  // Virtual channels and their numbering
  localparam int NUM_VC = 3;
  localparam int VC_WIDTH = 2;

  // Entries per input buffer
  localparam int VC_DEPTH = 4;
  // Pointer and occupancy widths for the buffer
  localparam int VC_PTR_WIDTH = $clog2(VC_DEPTH);
  localparam int VC_CNT_WIDTH = $clog2(VC_DEPTH + 1);

  // ****************************
  // Flit format
  // ****************************

  // Position of a flit inside its packet
  typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
    HEAD_FLIT = 2'b00,
    BODY_FLIT = 2'b01,
    TAIL_FLIT = 2'b10
  } flit_type_t;

  // Flit as it travels on the link and through the buffers
  typedef struct packed {
    logic                valid;
    logic [VC_WIDTH-1:0] vc_id;
    flit_type_t          ftype;
    logic [FLIT_DATA-1:0] fdata;
  } flit_t;

  // ****************************
  // Host side
  // ****************************

  // Host send request, one flit per transfer
  typedef struct packed {
    logic                 valid;
    // Marks the first flit of a packet
    logic                 req_new;
    // Marks the last flit of a packet
    logic                 req_last;
    logic [VC_WIDTH-1:0]  vc_id;
    logic [FLIT_DATA-1:0] flit_data;
  } s_pkt_out_req_t;

  typedef struct packed {
    logic ready;
  } s_pkt_out_resp_t;

  // Received flit toward the host, type already removed
  typedef struct packed {
    logic                 valid;
    logic [VC_WIDTH-1:0]  rq_vc;
    logic [FLIT_DATA-1:0] flit_data;
  } s_pkt_in_req_t;

  typedef struct packed {
    logic ready;
  } s_pkt_in_resp_t;

endpackage

`default_nettype wire

//--- source/pkt_proc.sv
// ****************************
// Packet processor of the local port
// Types host flits, strips type from link flits
// ****************************
`timescale 1ns/1ps
`default_nettype none

module pkt_proc (
  // Host send side
  input  ni_pkg::s_pkt_out_req_t  pkt_out_req,
  output ni_pkg::s_pkt_out_resp_t pkt_out_resp,

  // Toward the per-channel input buffers
  output ni_pkg::flit_t           buf_in [ni_pkg::NUM_VC],
  input  logic [ni_pkg::NUM_VC-1:0] buf_in_ready,

  // Link receive side
  input  ni_pkg::flit_t           link_in,
  output logic                    link_in_ready,

  // Host receive side
  output ni_pkg::s_pkt_in_req_t   pkt_in_req,
  input  ni_pkg::s_pkt_in_resp_t  pkt_in_resp
);

  // ****************************
  // Host -> input buffers
  // ****************************

  always_comb begin : to_buffers
    ni_pkg::flit_type_t ftype;

    // New wins over last, anything else is a body flit
    if (pkt_out_req.req_new) begin
      ftype = ni_pkg::HEAD_FLIT;
    end else if (pkt_out_req.req_last) begin
      ftype = ni_pkg::TAIL_FLIT;
    end else begin
      ftype = ni_pkg::BODY_FLIT;
    end

    // Same payload to every buffer, valid only on the addressed one
    for (int v = 0; v < ni_pkg::NUM_VC; v++) begin
      buf_in[v].valid = pkt_out_req.valid && (pkt_out_req.vc_id == ni_pkg::VC_WIDTH'(v));
      buf_in[v].vc_id = pkt_out_req.vc_id;
      buf_in[v].ftype = ftype;
      buf_in[v].fdata = pkt_out_req.flit_data;
    end

    // Ready comes back from the addressed buffer only
    // Channel numbers past NUM_VC never get ready
    pkt_out_resp.ready = 1'b0;
    if (pkt_out_req.vc_id < ni_pkg::VC_WIDTH'(ni_pkg::NUM_VC)) begin
      pkt_out_resp.ready = buf_in_ready[pkt_out_req.vc_id];
    end
  end

  // ****************************
  // Link -> host
  // ****************************

  always_comb begin : to_host
    pkt_in_req.valid = link_in.valid;
    pkt_in_req.rq_vc = link_in.vc_id;
    // Type bits are dropped here
    pkt_in_req.flit_data = link_in.fdata;
    link_in_ready = pkt_in_resp.ready;
  end

endmodule

`default_nettype wire

//--- vc_buffer/vc_buffer.sv
// ****************************
// Virtual-channel input buffer
// Circular FIFO, valid/ready on both sides
// ****************************
`timescale 1ns/1ps
`default_nettype none

module vc_buffer (
  input  logic          clk,
  input  logic          rst,
  // Write side
  input  ni_pkg::flit_t in_flit,
  output logic          in_ready,
  // Read side
  output ni_pkg::flit_t out_flit,
  input  logic          out_ready
);

  // Type and data kept as one link word, channel alongside
  logic [ni_pkg::FLIT_WIDTH-1:0]   mem_word [ni_pkg::VC_DEPTH];
  logic [ni_pkg::VC_WIDTH-1:0]     mem_vc   [ni_pkg::VC_DEPTH];

  logic [ni_pkg::VC_PTR_WIDTH-1:0] wr_ptr;
  logic [ni_pkg::VC_PTR_WIDTH-1:0] rd_ptr;
  logic [ni_pkg::VC_CNT_WIDTH-1:0] count;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign full  = (count == ni_pkg::VC_CNT_WIDTH'(ni_pkg::VC_DEPTH));
  assign empty = (count == '0);

  // A full buffer still takes a flit when it is being read
  assign in_ready = !full || out_ready;
  assign wr_en    = in_flit.valid && in_ready;
  assign rd_en    = !empty && out_ready;

  // Head entry shown straight from storage
  assign out_flit.valid = !empty;
  assign out_flit.vc_id = mem_vc[rd_ptr];
  assign out_flit.ftype = ni_pkg::flit_type_t'(mem_word[rd_ptr][ni_pkg::FLIT_WIDTH-1 -: 2]);
  assign out_flit.fdata = mem_word[rd_ptr][ni_pkg::FLIT_DATA-1:0];

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_word[wr_ptr] <= {in_flit.ftype, in_flit.fdata};
      mem_vc[wr_ptr]   <= in_flit.vc_id;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ni_pkg::VC_PTR_WIDTH'(ni_pkg::VC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ni_pkg::VC_PTR_WIDTH'(ni_pkg::VC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/vc_arbiter.sv
// ****************************
// Virtual-channel arbiter
// Round-robin, packet-atomic drain onto the link
// ****************************
`timescale 1ns/1ps
`default_nettype none

module vc_arbiter (
  input  logic                      clk,
  input  logic                      rst,
  // Heads of the input buffers
  input  ni_pkg::flit_t             req_flit [ni_pkg::NUM_VC],
  output logic [ni_pkg::NUM_VC-1:0] req_ready,
  // Outgoing link
  output ni_pkg::flit_t             link_out,
  input  logic                      link_out_ready
);

  // Next channel to look at first when unlocked
  logic [ni_pkg::VC_WIDTH-1:0] rr_ptr;
  // Channel that owns the link while a packet is open
  logic [ni_pkg::VC_WIDTH-1:0] lock_vc;
  logic                        locked;

  logic [ni_pkg::VC_WIDTH-1:0] grant;
  logic [ni_pkg::VC_WIDTH-1:0] next_ptr;
  logic                        xfer;

  // ****************************
  // Grant selection
  // ****************************

  always_comb begin : pick
    logic [ni_pkg::VC_WIDTH:0] idx;
    logic                      found;

    found = 1'b0;
    grant = rr_ptr;
    // First valid channel at or after the pointer, wrapping
    for (int i = 0; i < ni_pkg::NUM_VC; i++) begin
      idx = {1'b0, rr_ptr} + (ni_pkg::VC_WIDTH + 1)'(i);
      if (idx >= (ni_pkg::VC_WIDTH + 1)'(ni_pkg::NUM_VC)) begin
        idx = idx - (ni_pkg::VC_WIDTH + 1)'(ni_pkg::NUM_VC);
      end
      if (!found && req_flit[idx[ni_pkg::VC_WIDTH-1:0]].valid) begin
        grant = idx[ni_pkg::VC_WIDTH-1:0];
        found = 1'b1;
      end
    end
    // An open packet keeps its channel
    if (locked) begin
      grant = lock_vc;
    end
  end

  // Pointer moves one past the channel just served
  assign next_ptr = (grant == ni_pkg::VC_WIDTH'(ni_pkg::NUM_VC - 1)) ? '0 : grant + 1'b1;

  // Link driven straight from the granted buffer
  assign link_out = req_flit[grant];
  assign xfer     = link_out.valid && link_out_ready;

  always_comb begin : ready_steer
    req_ready        = '0;
    // Only the granted buffer sees the link's ready
    req_ready[grant] = link_out_ready;
  end

  // ****************************
  // Lock and pointer state
  // ****************************

  always_ff @(posedge clk) begin
    if (rst) begin
      locked  <= 1'b0;
      lock_vc <= '0;
      rr_ptr  <= '0;
    end else if (xfer && link_out.ftype == ni_pkg::TAIL_FLIT) begin
      // Packet done, reopen arbitration
      locked <= 1'b0;
      rr_ptr <= next_ptr;
    end else if (link_out.valid && link_out.ftype == ni_pkg::HEAD_FLIT) begin
      // Lock as soon as a head is shown, so a stalled head
      // cannot be replaced by another channel
      locked  <= 1'b1;
      lock_vc <= grant;
    end
  end

endmodule

`default_nettype wire

//--- source/ni_top.sv
// ****************************
// Network interface local port
// Packet processor, VC buffers and link arbiter
// ****************************
`timescale 1ns/1ps
`default_nettype none

module ni_top (
  input  logic                    clk,
  input  logic                    rst,
  // Host
  input  ni_pkg::s_pkt_out_req_t  pkt_out_req,
  output ni_pkg::s_pkt_out_resp_t pkt_out_resp,
  output ni_pkg::s_pkt_in_req_t   pkt_in_req,
  input  ni_pkg::s_pkt_in_resp_t  pkt_in_resp,
  // Link
  input  ni_pkg::flit_t           link_in,
  output logic                    link_in_ready,
  output ni_pkg::flit_t           link_out,
  input  logic                    link_out_ready
);

  // Packet processor to buffers
  ni_pkg::flit_t             buf_in [ni_pkg::NUM_VC];
  logic [ni_pkg::NUM_VC-1:0] buf_in_ready;

  // Buffers to arbiter
  ni_pkg::flit_t             buf_out [ni_pkg::NUM_VC];
  logic [ni_pkg::NUM_VC-1:0] buf_out_ready;

  pkt_proc i_pkt_proc (
    .pkt_out_req   (pkt_out_req),
    .pkt_out_resp  (pkt_out_resp),
    .buf_in        (buf_in),
    .buf_in_ready  (buf_in_ready),
    .link_in       (link_in),
    .link_in_ready (link_in_ready),
    .pkt_in_req    (pkt_in_req),
    .pkt_in_resp   (pkt_in_resp)
  );

  // One input buffer per virtual channel
  for (genvar gv = 0; gv < ni_pkg::NUM_VC; gv++) begin : gen_vc
    vc_buffer i_vc_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (buf_in[gv]),
      .in_ready  (buf_in_ready[gv]),
      .out_flit  (buf_out[gv]),
      .out_ready (buf_out_ready[gv])
    );
  end

  vc_arbiter i_vc_arbiter (
    .clk            (clk),
    .rst            (rst),
    .req_flit       (buf_out),
    .req_ready      (buf_out_ready),
    .link_out       (link_out),
    .link_out_ready (link_out_ready)
  );

endmodule

`default_nettype wire

//--- tb/ni_assertions.sv
// ****************************
// Link and host port assertions
// ****************************
`timescale 1ns/1ps
`default_nettype none

module ni_assertions (
  input logic                  clk,
  input logic                  rst,
  input ni_pkg::flit_t         link_out,
  input logic                  link_out_ready,
  input ni_pkg::s_pkt_in_req_t pkt_in_req
);

  // Channel of the packet currently on the link
  logic                        pkt_open;
  logic [ni_pkg::VC_WIDTH-1:0] open_vc;

  // Number of failed assertions so far
  int assert_fails = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_open <= 1'b0;
      open_vc  <= '0;
    end else if (link_out.valid && link_out_ready) begin
      if (link_out.ftype == ni_pkg::HEAD_FLIT) begin
        pkt_open <= 1'b1;
        open_vc  <= link_out.vc_id;
      end else if (link_out.ftype == ni_pkg::TAIL_FLIT) begin
        pkt_open <= 1'b0;
      end
    end
  end

  // Stalled link keeps its flit
  a_link_hold: assert property (@(posedge clk) disable iff (rst)
    link_out.valid && !link_out_ready |=> $stable(link_out))
    else begin
      $error("link_out changed while link_out_ready was low");
      assert_fails++;
    end

  // No other channel inside an open packet
  a_atomic: assert property (@(posedge clk) disable iff (rst)
    pkt_open && link_out.valid |-> link_out.vc_id == open_vc)
    else begin
      $error("link_out switched channel inside a packet");
      assert_fails++;
    end

  // Quiet outputs right after reset
  a_reset_idle: assert property (@(posedge clk)
    rst |=> !link_out.valid && !pkt_in_req.valid)
    else begin
      $error("valid output seen right after reset");
      assert_fails++;
    end

endmodule

`default_nettype wire

//--- tb/tb_ni_top.sv
// ****************************
// Testbench for the NI local port
// File-driven sends and receives, scoreboard per channel
// ****************************
`timescale 1ns/1ps
`default_nettype none

module tb_ni_top;

  // One parsed line of the test file
  typedef struct packed {
    logic [7:0]  tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
  } test_line_t;

  logic                    clk;
  logic                    rst;
  ni_pkg::s_pkt_out_req_t  pkt_out_req;
  ni_pkg::s_pkt_out_resp_t pkt_out_resp;
  ni_pkg::s_pkt_in_req_t   pkt_in_req;
  ni_pkg::s_pkt_in_resp_t  pkt_in_resp;
  ni_pkg::flit_t           link_in;
  logic                    link_in_ready;
  ni_pkg::flit_t           link_out;
  logic                    link_out_ready;

  test_line_t tests[$];
  // Expected {type, data} per channel, in send order
  logic [ni_pkg::FLIT_WIDTH-1:0] exp_q [ni_pkg::NUM_VC][$];

  logic [31:0] lfsr;
  int          hold_cnt;
  int          err_value;
  int          err_other;
  int          err_assert;
  int          full_stalls;
  int          cycle_cnt;
  int          cycle_limit;
  logic        limit_set;
  logic        sb_open;
  logic [ni_pkg::VC_WIDTH-1:0] sb_vc;

  ni_top i_ni_top (
    .clk            (clk),
    .rst            (rst),
    .pkt_out_req    (pkt_out_req),
    .pkt_out_resp   (pkt_out_resp),
    .pkt_in_req     (pkt_in_req),
    .pkt_in_resp    (pkt_in_resp),
    .link_in        (link_in),
    .link_in_ready  (link_in_ready),
    .link_out       (link_out),
    .link_out_ready (link_out_ready)
  );

  bind ni_top ni_assertions i_ni_assertions (
    .clk            (clk),
    .rst            (rst),
    .link_out       (link_out),
    .link_out_ready (link_out_ready),
    .pkt_in_req     (pkt_in_req)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ****************************
  // Helpers
  // ****************************

  task automatic check_value(input string name, input logic [ni_pkg::FLIT_WIDTH-1:0] got,
                             input logic [ni_pkg::FLIT_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_value++;
    end
  endtask

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  // New has priority over last
  function automatic logic [1:0] expected_type(input logic is_new, input logic is_last);
    if (is_new) begin
      return ni_pkg::HEAD_FLIT;
    end else if (is_last) begin
      return ni_pkg::TAIL_FLIT;
    end
    return ni_pkg::BODY_FLIT;
  endfunction

  function automatic logic queues_empty();
    for (int v = 0; v < ni_pkg::NUM_VC; v++) begin
      if (exp_q[v].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic load_tests();
    int         fd;
    int         n;
    string      line;
    test_line_t t;
    fd = $fopen("tb/ni_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/ni_tests.txt");
      err_other++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        t = '0;
        t.tag = (line.len() > 0) ? line.getc(0) : 8'h00;
        n = 0;
        case (t.tag)
          "S": n = $sscanf(line, "S %h %h %h %h", t.a, t.b, t.c, t.d);
          "R": n = $sscanf(line, "R %h %h %h %h", t.a, t.b, t.c, t.d);
          "H": n = $sscanf(line, "H %d", t.a) + 3;
          default: n = -1;
        endcase
        if (n == 4) begin
          tests.push_back(t);
        end else if (n >= 0) begin
          $display("malformed test line: %s", line);
          err_other++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Falling edge: clear valids, draw new ready bits
  task automatic start_cycle();
    logic a;
    logic b;
    logic c;
    @(negedge clk);
    pkt_out_req.valid = 1'b0;
    link_in.valid     = 1'b0;
    take_bit(a);
    take_bit(b);
    take_bit(c);
    if (hold_cnt > 0) begin
      link_out_ready = 1'b0;
      hold_cnt--;
    end else begin
      link_out_ready = a | b;
    end
    pkt_in_resp.ready = c;
  endtask

  task automatic idle_cycle();
    start_cycle();
    @(posedge clk);
  endtask

  // Hold the flit until the buffer takes it
  task automatic send_flit(input logic [1:0] vc, input logic is_new, input logic is_last,
                           input logic [31:0] data);
    logic done;
    done = 1'b0;
    while (!done) begin
      start_cycle();
      pkt_out_req.valid     = 1'b1;
      pkt_out_req.req_new   = is_new;
      pkt_out_req.req_last  = is_last;
      pkt_out_req.vc_id     = vc;
      pkt_out_req.flit_data = data;
      @(posedge clk);
      done = pkt_out_resp.ready;
    end
  endtask

  // Link flit toward the host, checked every cycle it is offered
  task automatic inject_flit(input logic [1:0] vc, input logic [1:0] ftype,
                             input logic [31:0] data, input logic [31:0] exp_data);
    logic done;
    done = 1'b0;
    while (!done) begin
      start_cycle();
      link_in.valid = 1'b1;
      link_in.vc_id = vc;
      link_in.ftype = ni_pkg::flit_type_t'(ftype);
      link_in.fdata = data;
      @(posedge clk);
      check_value("pkt_in_req.valid", pkt_in_req.valid, 1'b1);
      check_value("pkt_in_req.rq_vc", pkt_in_req.rq_vc, vc);
      check_value("pkt_in_req.flit_data", pkt_in_req.flit_data, exp_data);
      check_value("link_in_ready", link_in_ready, pkt_in_resp.ready);
      done = link_in_ready;
    end
  endtask

  // ****************************
  // Scoreboard on the link side
  // ****************************

  always @(posedge clk) begin : scoreboard
    logic [ni_pkg::VC_WIDTH-1:0]   v;
    logic [ni_pkg::FLIT_WIDTH-1:0] exp_flit;
    if (!rst) begin
      // Stalled link, so ready follows buffer occupancy alone
      if (pkt_out_req.valid && !link_out_ready) begin
        check_value("pkt_out_resp.ready", pkt_out_resp.ready,
                    exp_q[pkt_out_req.vc_id].size() < ni_pkg::VC_DEPTH);
        if (!pkt_out_resp.ready) begin
          full_stalls++;
        end
      end
      if (link_out.valid && link_out_ready) begin
        v = link_out.vc_id;
        if (exp_q[v].size() == 0) begin
          $display("flit %h left on channel %0d with nothing sent there", link_out.fdata, v);
          err_other++;
        end else begin
          exp_flit = exp_q[v].pop_front();
          check_value("link_out.ftype", link_out.ftype, exp_flit[ni_pkg::FLIT_WIDTH-1 -: 2]);
          check_value("link_out.fdata", link_out.fdata, exp_flit[ni_pkg::FLIT_DATA-1:0]);
        end
        // Packet atomicity
        if (sb_open && v != sb_vc) begin
          $display("channel %0d interleaved into the open packet of channel %0d", v, sb_vc);
          err_other++;
        end
        if (link_out.ftype == ni_pkg::HEAD_FLIT) begin
          sb_open = 1'b1;
          sb_vc   = v;
        end else if (link_out.ftype == ni_pkg::TAIL_FLIT) begin
          sb_open = 1'b0;
        end
      end
      if (pkt_out_req.valid && pkt_out_resp.ready) begin
        exp_q[pkt_out_req.vc_id].push_back({expected_type(pkt_out_req.req_new,
                                            pkt_out_req.req_last), pkt_out_req.flit_data});
      end
    end
  end

  // ****************************
  // Main sequence
  // ****************************

  initial begin : main
    test_line_t t;
    int         i;
    rst            = 1'b1;
    pkt_out_req    = '0;
    pkt_in_resp    = '0;
    link_in        = '0;
    link_out_ready = 1'b0;
    lfsr           = 32'hff48eea9;
    hold_cnt       = 0;
    err_value      = 0;
    err_other      = 0;
    err_assert     = 0;
    full_stalls    = 0;
    sb_open        = 1'b0;
    sb_vc          = '0;
    limit_set      = 1'b0;
    load_tests();
    cycle_limit = 20 * tests.size() + 200;
    limit_set   = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_cycle();
    foreach (tests[k]) begin
      t = tests[k];
      case (t.tag)
        "S": send_flit(t.a[1:0], t.b[0], t.c[0], t.d);
        "R": inject_flit(t.a[1:0], t.b[1:0], t.c, t.d);
        // Stall the link for the given number of cycles
        default: hold_cnt = t.a;
      endcase
    end
    // Let the buffers drain
    for (i = 0; i < 100 && !queues_empty(); i++) begin
      idle_cycle();
    end
    // Scoreboard updates of the last edge are settled here
    @(negedge clk);
    for (int v = 0; v < ni_pkg::NUM_VC; v++) begin
      if (exp_q[v].size() != 0) begin
        $display("channel %0d still expects %0d flits at the end", v, exp_q[v].size());
        err_other++;
      end
    end
    if (full_stalls == 0) begin
      $display("no buffer ever filled up under a stalled link");
      err_other++;
    end
    err_assert = i_ni_top.i_ni_assertions.assert_fails;
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             err_value, err_other, err_assert);
    if (err_value == 0 && err_other == 0 && err_assert == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Cycle budget grows with the number of test lines
  initial begin : watchdog
    cycle_cnt = 0;
    wait (limit_set);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/ni_tests.txt
# S vc new last data       : host sends one flit on channel vc (all hex)
# R vc type data exp_data  : flit injected on the link, exp_data expected at the host
# H n                      : link_out_ready held low for n cycles (decimal)
S 0 1 0 a0000001
S 0 0 0 a0000002
S 0 0 1 a0000003
S 1 1 0 b0000001
S 2 1 0 c0000001
S 1 0 1 b0000002
S 2 0 0 c0000002
S 2 0 1 c0000003
R 1 0 12345678 12345678
R 2 2 deadbeef deadbeef
S 1 1 1 b0000010
S 1 0 1 b0000011
S 0 1 0 a0000010
S 0 0 1 a0000011
R 0 1 0badf00d 0badf00d
H 10
S 2 1 0 c0000010
S 2 0 0 c0000011
S 2 0 0 c0000012
S 2 0 0 c0000013
S 2 0 0 c0000014
S 2 0 1 c0000015
S 0 1 0 a0000020
S 1 1 0 b0000020
S 0 0 1 a0000021
S 1 0 0 b0000021
S 1 0 1 b0000022
R 1 1 ffff0000 ffff0000
R 0 0 00000001 00000001
S 2 1 1 c0000020
S 2 0 0 c0000021
S 2 0 1 c0000022
R 2 1 13572468 13572468
S 0 1 0 a0000030
S 0 0 0 a0000031
S 0 0 0 a0000032
S 0 0 0 a0000033
S 0 0 1 a0000034
R 0 2 cafe0001 cafe0001

//--- tb.f
common/ni_pkg.sv
source/pkt_proc.sv
vc_buffer/vc_buffer.sv
source/vc_arbiter.sv
source/ni_top.sv
tb/ni_assertions.sv
tb/tb_ni_top.sv

//--- Bender.yml
package:
  name: ni_top

sources:
  - common/ni_pkg.sv
  - source/pkt_proc.sv
  - vc_buffer/vc_buffer.sv
  - source/vc_arbiter.sv
  - source/ni_top.sv
  - target: test
    files:
      - tb/ni_assertions.sv
      - tb/tb_ni_top.sv
